/* Bender.yml */
package:
  name: exec_pipe

sources:
  - hw/pipeCfgPkg.sv
  - hw/aluOpsPkg.sv
  - hw/regFile.sv
  - hw/stageId.sv
  - hw/alu.sv
  - hw/forwardController.sv
  - hw/stageEx.sv
  - hw/stageMemWb.sv
  - hw/execPipe.sv
  - target: test
    files:
      - tb/execPipe_tb.sv

/* all.f */
hw/pipeCfgPkg.sv
hw/aluOpsPkg.sv
hw/regFile.sv
hw/stageId.sv
hw/alu.sv
hw/forwardController.sv
hw/stageEx.sv
hw/stageMemWb.sv
hw/execPipe.sv
tb/execPipe_tb.sv

/* hw/alu.sv */
// combinational integer alu
`timescale 1ns/1ps

module alu (
    input  aluOpsPkg::AluOp                  i_Op,
    input  logic [pipeCfgPkg::DataWidth-1:0] i_OperandA,
    input  logic [pipeCfgPkg::DataWidth-1:0] i_OperandB,
    output logic [pipeCfgPkg::DataWidth-1:0] o_Result
);
    import aluOpsPkg::*;

    logic [4:0] shiftAmount;
    logic       lessThan;

    assign shiftAmount = i_OperandB[4:0];
    // two's complement compare
    assign lessThan    = $signed(i_OperandA) < $signed(i_OperandB);

    always_comb begin
        o_Result = '0;
        case (i_Op)
            ALU_ADD: o_Result = i_OperandA + i_OperandB;
            ALU_SUB: o_Result = i_OperandA - i_OperandB;
            ALU_AND: o_Result = i_OperandA & i_OperandB;
            ALU_OR:  o_Result = i_OperandA | i_OperandB;
            ALU_XOR: o_Result = i_OperandA ^ i_OperandB;
            ALU_NOR: o_Result = ~(i_OperandA | i_OperandB);
            // result is 0 or 1
            ALU_SLT: o_Result[0] = lessThan;
            ALU_SLL: o_Result = i_OperandA << shiftAmount;
            ALU_SRL: o_Result = i_OperandA >> shiftAmount;
            // unknown opcode
            default: o_Result = '0;
        endcase
    end

endmodule

/* hw/aluOpsPkg.sv */
// alu operation codes
package aluOpsPkg;

    // shifts take operand b bits 4..0 as amount, applied to operand a
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOR = 4'd5,
        // signed compare
        ALU_SLT = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SRL = 4'd8
    } AluOp;

endpackage

/* hw/execPipe.sv */
// top level joining register file, decode, execute and memory/writeback stages
`timescale 1ns/1ps

module execPipe (
    input  logic                                i_Clock,
    input  logic                                i_rstN,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_InstRS,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_InstRT,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_InstRD,
    input  logic [pipeCfgPkg::DataWidth-1:0]    i_InstIMM,
    input  aluOpsPkg::AluOp                     i_AluControl,
    input  logic                                i_AluSrcB,
    input  logic                                i_RegDst,
    input  logic                                i_MemWrEnable,
    input  logic                                i_MemToReg,
    input  logic                                i_RegWrEnable,
    output logic [pipeCfgPkg::DataWidth-1:0]    o_WbResult,
    output logic [pipeCfgPkg::RegAddrWidth-1:0] o_WbWriteReg,
    output logic                                o_WbRegWrEnable
);
    import pipeCfgPkg::*;
    import aluOpsPkg::*;

    // register file read side
    logic [RegAddrWidth-1:0] rdAddrA, rdAddrB;
    logic [DataWidth-1:0]    rdDataA, rdDataB;

    // ID/EX
    logic [DataWidth-1:0]    idDataA, idDataB, idInstIMM;
    logic [RegAddrWidth-1:0] idInstRS, idInstRT, idInstRD;
    AluOp                    idAluControl;
    logic                    idAluSrcB, idRegDst;
    logic                    idMemWrEnable, idMemToReg, idRegWrEnable;

    // EX/MEM
    logic [DataWidth-1:0]    exAluResult, exWriteData;
    logic [RegAddrWidth-1:0] exWriteReg;
    logic                    exRegWrEnable, exMemWrEnable, exMemToReg;

    // writeback also drives the register file write port
    regFile regFile_i (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_RdAddrA  (rdAddrA),
        .i_RdAddrB  (rdAddrB),
        .i_WrEnable (o_WbRegWrEnable),
        .i_WrAddr   (o_WbWriteReg),
        .i_WrData   (o_WbResult),
        .o_RdDataA  (rdDataA),
        .o_RdDataB  (rdDataB)
    );

    stageId stageId_i (
        .i_Clock       (i_Clock),
        .i_rstN        (i_rstN),
        .i_InstRS      (i_InstRS),
        .i_InstRT      (i_InstRT),
        .i_InstRD      (i_InstRD),
        .i_InstIMM     (i_InstIMM),
        .i_AluControl  (i_AluControl),
        .i_AluSrcB     (i_AluSrcB),
        .i_RegDst      (i_RegDst),
        .i_MemWrEnable (i_MemWrEnable),
        .i_MemToReg    (i_MemToReg),
        .i_RegWrEnable (i_RegWrEnable),
        .i_RdDataA     (rdDataA),
        .i_RdDataB     (rdDataB),
        .o_RdAddrA     (rdAddrA),
        .o_RdAddrB     (rdAddrB),
        .o_DataA       (idDataA),
        .o_DataB       (idDataB),
        .o_InstRS      (idInstRS),
        .o_InstRT      (idInstRT),
        .o_InstRD      (idInstRD),
        .o_InstIMM     (idInstIMM),
        .o_AluControl  (idAluControl),
        .o_AluSrcB     (idAluSrcB),
        .o_RegDst      (idRegDst),
        .o_MemWrEnable (idMemWrEnable),
        .o_MemToReg    (idMemToReg),
        .o_RegWrEnable (idRegWrEnable)
    );

    stageEx stageEx_i (
        .i_Clock            (i_Clock),
        .i_rstN             (i_rstN),
        .i_DataA            (idDataA),
        .i_DataB            (idDataB),
        .i_InstRS           (idInstRS),
        .i_InstRT           (idInstRT),
        .i_InstRD           (idInstRD),
        .i_InstIMM          (idInstIMM),
        .i_AluControl       (idAluControl),
        .i_AluSrcB          (idAluSrcB),
        .i_RegDst           (idRegDst),
        .i_MemWrEnable      (idMemWrEnable),
        .i_MemToReg         (idMemToReg),
        .i_RegWrEnable      (idRegWrEnable),
        .i_WbFwdResult      (o_WbResult),
        .i_WbFwdWriteReg    (o_WbWriteReg),
        .i_WbFwdRegWrEnable (o_WbRegWrEnable),
        .o_AluResult        (exAluResult),
        .o_WriteData        (exWriteData),
        .o_WriteReg         (exWriteReg),
        .o_RegWrEnable      (exRegWrEnable),
        .o_MemWrEnable      (exMemWrEnable),
        .o_MemToReg         (exMemToReg)
    );

    stageMemWb stageMemWb_i (
        .i_Clock         (i_Clock),
        .i_rstN          (i_rstN),
        .i_AluResult     (exAluResult),
        .i_WriteData     (exWriteData),
        .i_WriteReg      (exWriteReg),
        .i_RegWrEnable   (exRegWrEnable),
        .i_MemWrEnable   (exMemWrEnable),
        .i_MemToReg      (exMemToReg),
        .o_WbResult      (o_WbResult),
        .o_WbWriteReg    (o_WbWriteReg),
        .o_WbRegWrEnable (o_WbRegWrEnable)
    );

endmodule

/* hw/forwardController.sv */
// operand forwarding source select for the execute stage
`timescale 1ns/1ps

module forwardController (
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_InstRS,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_InstRT,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_ExMemWriteReg,
    input  logic                                i_ExMemRegWrEnable,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_MemWbWriteReg,
    input  logic                                i_MemWbRegWrEnable,
    output pipeCfgPkg::FwdSel                   o_DataASelect,
    output pipeCfgPkg::FwdSel                   o_DataBSelect
);
    import pipeCfgPkg::*;

    logic exMemWrites;
    logic memWbWrites;

    // register 0 is never a producer
    assign exMemWrites = i_ExMemRegWrEnable && (i_ExMemWriteReg != '0);
    assign memWbWrites = i_MemWbRegWrEnable && (i_MemWbWriteReg != '0);

    // newest producer wins
    assign o_DataASelect = (exMemWrites && (i_ExMemWriteReg == i_InstRS)) ? FWD_MEM :
                           (memWbWrites && (i_MemWbWriteReg == i_InstRS)) ? FWD_WB :
                           FWD_NONE;

    assign o_DataBSelect = (exMemWrites && (i_ExMemWriteReg == i_InstRT)) ? FWD_MEM :
                           (memWbWrites && (i_MemWbWriteReg == i_InstRT)) ? FWD_WB :
                           FWD_NONE;

endmodule

/* hw/pipeCfgPkg.sv */
// datapath widths, data memory depth and operand forwarding sources
package pipeCfgPkg;

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------
    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int RegCount     = 32;

    // word address bits, 64 words taken from alu result bits 7..2
    localparam int DmemAddrWidth = 6;

    // ----------------------------------------------------------------------
    // operand source in execute
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_WB   = 2'd1,
        FWD_MEM  = 2'd2
    } FwdSel;

endpackage

/* hw/regFile.sv */
// register file with two combinational read ports, one write port and write bypass
`timescale 1ns/1ps

module regFile (
    input  logic                                i_Clock,
    input  logic                                i_rstN,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_RdAddrA,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_RdAddrB,
    input  logic                                i_WrEnable,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_WrAddr,
    input  logic [pipeCfgPkg::DataWidth-1:0]    i_WrData,
    output logic [pipeCfgPkg::DataWidth-1:0]    o_RdDataA,
    output logic [pipeCfgPkg::DataWidth-1:0]    o_RdDataB
);
    import pipeCfgPkg::*;

    logic [DataWidth-1:0] regs [RegCount];

    // register 0 is never written
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (i_WrEnable && (i_WrAddr != '0)) begin
            regs[i_WrAddr] <= i_WrData;
        end
    end

    // zero register first, then same-cycle write, then storage
    assign o_RdDataA = (i_RdAddrA == '0) ? '0 :
                       (i_WrEnable && (i_WrAddr == i_RdAddrA)) ? i_WrData :
                       regs[i_RdAddrA];

    assign o_RdDataB = (i_RdAddrB == '0) ? '0 :
                       (i_WrEnable && (i_WrAddr == i_RdAddrB)) ? i_WrData :
                       regs[i_RdAddrB];

endmodule

/* hw/stageEx.sv */
// execute stage with forwarding, immediate select, alu and EX/MEM register
`timescale 1ns/1ps

module stageEx (
    input  logic                                i_Clock,
    input  logic                                i_rstN,
    input  logic [pipeCfgPkg::DataWidth-1:0]    i_DataA,
    input  logic [pipeCfgPkg::DataWidth-1:0]    i_DataB,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_InstRS,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_InstRT,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_InstRD,
    input  logic [pipeCfgPkg::DataWidth-1:0]    i_InstIMM,
    input  aluOpsPkg::AluOp                     i_AluControl,
    input  logic                                i_AluSrcB,
    input  logic                                i_RegDst,
    input  logic                                i_MemWrEnable,
    input  logic                                i_MemToReg,
    input  logic                                i_RegWrEnable,
    input  logic [pipeCfgPkg::DataWidth-1:0]    i_WbFwdResult,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_WbFwdWriteReg,
    input  logic                                i_WbFwdRegWrEnable,
    output logic [pipeCfgPkg::DataWidth-1:0]    o_AluResult,
    output logic [pipeCfgPkg::DataWidth-1:0]    o_WriteData,
    output logic [pipeCfgPkg::RegAddrWidth-1:0] o_WriteReg,
    output logic                                o_RegWrEnable,
    output logic                                o_MemWrEnable,
    output logic                                o_MemToReg
);
    import pipeCfgPkg::*;
    import aluOpsPkg::*;

    FwdSel                 dataASelect;
    FwdSel                 dataBSelect;
    logic [DataWidth-1:0]  fwdDataA;
    logic [DataWidth-1:0]  fwdDataB;
    logic [DataWidth-1:0]  aluOperandB;
    logic [DataWidth-1:0]  aluResult;
    logic [RegAddrWidth-1:0] writeReg;

    // ----------------------------------------------------------------------
    // forwarding
    // ----------------------------------------------------------------------
    // EX/MEM outputs feed back as the newest producer
    forwardController forwardController_i (
        .i_InstRS           (i_InstRS),
        .i_InstRT           (i_InstRT),
        .i_ExMemWriteReg    (o_WriteReg),
        .i_ExMemRegWrEnable (o_RegWrEnable),
        .i_MemWbWriteReg    (i_WbFwdWriteReg),
        .i_MemWbRegWrEnable (i_WbFwdRegWrEnable),
        .o_DataASelect      (dataASelect),
        .o_DataBSelect      (dataBSelect)
    );

    always_comb begin
        case (dataASelect)
            FWD_MEM: fwdDataA = o_AluResult;
            FWD_WB:  fwdDataA = i_WbFwdResult;
            default: fwdDataA = i_DataA;
        endcase
        case (dataBSelect)
            FWD_MEM: fwdDataB = o_AluResult;
            FWD_WB:  fwdDataB = i_WbFwdResult;
            default: fwdDataB = i_DataB;
        endcase
    end

    // ----------------------------------------------------------------------
    // alu and destination
    // ----------------------------------------------------------------------
    // immediate only at the alu input, store data keeps forwarded b
    assign aluOperandB = i_AluSrcB ? i_InstIMM : fwdDataB;
    assign writeReg    = i_RegDst ? i_InstRD : i_InstRT;

    alu alu_i (
        .i_Op       (i_AluControl),
        .i_OperandA (fwdDataA),
        .i_OperandB (aluOperandB),
        .o_Result   (aluResult)
    );

    // ----------------------------------------------------------------------
    // EX/MEM register
    // ----------------------------------------------------------------------
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_RegWrEnable <= 1'b0;
            o_MemWrEnable <= 1'b0;
            o_MemToReg    <= 1'b0;
        end else begin
            o_RegWrEnable <= i_RegWrEnable;
            o_MemWrEnable <= i_MemWrEnable;
            o_MemToReg    <= i_MemToReg;
        end
    end

    always_ff @(posedge i_Clock) begin
        o_AluResult <= aluResult;
        o_WriteData <= fwdDataB;
        o_WriteReg  <= writeReg;
    end

endmodule

/* hw/stageId.sv */
// decode stage, register file read addresses and ID/EX pipeline register
`timescale 1ns/1ps

module stageId (
    input  logic                                i_Clock,
    input  logic                                i_rstN,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_InstRS,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_InstRT,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_InstRD,
    input  logic [pipeCfgPkg::DataWidth-1:0]    i_InstIMM,
    input  aluOpsPkg::AluOp                     i_AluControl,
    input  logic                                i_AluSrcB,
    input  logic                                i_RegDst,
    input  logic                                i_MemWrEnable,
    input  logic                                i_MemToReg,
    input  logic                                i_RegWrEnable,
    input  logic [pipeCfgPkg::DataWidth-1:0]    i_RdDataA,
    input  logic [pipeCfgPkg::DataWidth-1:0]    i_RdDataB,
    output logic [pipeCfgPkg::RegAddrWidth-1:0] o_RdAddrA,
    output logic [pipeCfgPkg::RegAddrWidth-1:0] o_RdAddrB,
    output logic [pipeCfgPkg::DataWidth-1:0]    o_DataA,
    output logic [pipeCfgPkg::DataWidth-1:0]    o_DataB,
    output logic [pipeCfgPkg::RegAddrWidth-1:0] o_InstRS,
    output logic [pipeCfgPkg::RegAddrWidth-1:0] o_InstRT,
    output logic [pipeCfgPkg::RegAddrWidth-1:0] o_InstRD,
    output logic [pipeCfgPkg::DataWidth-1:0]    o_InstIMM,
    output aluOpsPkg::AluOp                     o_AluControl,
    output logic                                o_AluSrcB,
    output logic                                o_RegDst,
    output logic                                o_MemWrEnable,
    output logic                                o_MemToReg,
    output logic                                o_RegWrEnable
);
    import pipeCfgPkg::*;
    import aluOpsPkg::*;

    // register file is read in the same cycle the instruction arrives
    assign o_RdAddrA = i_InstRS;
    assign o_RdAddrB = i_InstRT;

    // ----------------------------------------------------------------------
    // ID/EX register
    // ----------------------------------------------------------------------
    // enables cleared so nothing writes after reset
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_MemWrEnable <= 1'b0;
            o_MemToReg    <= 1'b0;
            o_RegWrEnable <= 1'b0;
        end else begin
            o_MemWrEnable <= i_MemWrEnable;
            o_MemToReg    <= i_MemToReg;
            o_RegWrEnable <= i_RegWrEnable;
        end
    end

    // operands and fields
    always_ff @(posedge i_Clock) begin
        o_DataA      <= i_RdDataA;
        o_DataB      <= i_RdDataB;
        o_InstRS     <= i_InstRS;
        o_InstRT     <= i_InstRT;
        o_InstRD     <= i_InstRD;
        o_InstIMM    <= i_InstIMM;
        o_AluControl <= i_AluControl;
        o_AluSrcB    <= i_AluSrcB;
        o_RegDst     <= i_RegDst;
    end

endmodule

/* hw/stageMemWb.sv */
// memory/writeback stage with data memory, MEM/WB register and result select
`timescale 1ns/1ps

module stageMemWb (
    input  logic                                i_Clock,
    input  logic                                i_rstN,
    input  logic [pipeCfgPkg::DataWidth-1:0]    i_AluResult,
    input  logic [pipeCfgPkg::DataWidth-1:0]    i_WriteData,
    input  logic [pipeCfgPkg::RegAddrWidth-1:0] i_WriteReg,
    input  logic                                i_RegWrEnable,
    input  logic                                i_MemWrEnable,
    input  logic                                i_MemToReg,
    output logic [pipeCfgPkg::DataWidth-1:0]    o_WbResult,
    output logic [pipeCfgPkg::RegAddrWidth-1:0] o_WbWriteReg,
    output logic                                o_WbRegWrEnable
);
    import pipeCfgPkg::*;

    logic [DataWidth-1:0]     dmem [2**DmemAddrWidth];
    logic [DmemAddrWidth-1:0] dmemAddr;
    logic [DataWidth-1:0]     loadWord;
    logic [DataWidth-1:0]     wbLoadWord;
    logic [DataWidth-1:0]     wbAluResult;
    logic                     wbMemToReg;

    // word address, byte offset dropped
    assign dmemAddr = i_AluResult[DmemAddrWidth+1:2];

    // ----------------------------------------------------------------------
    // data memory
    // ----------------------------------------------------------------------
    // store lands at the edge it leaves EX/MEM
    always_ff @(posedge i_Clock) begin
        if (i_MemWrEnable) begin
            dmem[dmemAddr] <= i_WriteData;
        end
    end

    // combinational load
    assign loadWord = dmem[dmemAddr];

    // ----------------------------------------------------------------------
    // MEM/WB register
    // ----------------------------------------------------------------------
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_WbRegWrEnable <= 1'b0;
            wbMemToReg      <= 1'b0;
        end else begin
            o_WbRegWrEnable <= i_RegWrEnable;
            wbMemToReg      <= i_MemToReg;
        end
    end

    always_ff @(posedge i_Clock) begin
        wbLoadWord   <= loadWord;
        wbAluResult  <= i_AluResult;
        o_WbWriteReg <= i_WriteReg;
    end

    // loaded word or alu result
    assign o_WbResult = wbMemToReg ? wbLoadWord : wbAluResult;

endmodule

/* tb/execPipe_tb.sv */
// testbench for the execute pipeline with file driven stimulus and delayed writeback checks
`timescale 1ns/1ps

module execPipe_tb;
    import pipeCfgPkg::*;
    import aluOpsPkg::*;

    // columns of one test data line
    localparam int ColRs        = 0;
    localparam int ColRt        = 1;
    localparam int ColRd        = 2;
    localparam int ColImm       = 3;
    localparam int ColOp        = 4;
    localparam int ColAluSrcB   = 5;
    localparam int ColRegDst    = 6;
    localparam int ColMemWr     = 7;
    localparam int ColMemToReg  = 8;
    localparam int ColRegWr     = 9;
    localparam int ColExpWe     = 10;
    localparam int ColExpReg    = 11;
    localparam int ColExpResult = 12;
    localparam int ColCount     = 13;

    localparam int MaxInst      = 64;
    // edges from presenting an instruction to its writeback
    localparam int WbLatency    = 3;
    localparam int TimeoutSlack = 20;
    localparam DataFile         = "tb/execPipe_testdata.txt";

    logic                    i_Clock;
    logic                    i_rstN;
    logic [RegAddrWidth-1:0] i_InstRS;
    logic [RegAddrWidth-1:0] i_InstRT;
    logic [RegAddrWidth-1:0] i_InstRD;
    logic [DataWidth-1:0]    i_InstIMM;
    AluOp                    i_AluControl;
    logic                    i_AluSrcB;
    logic                    i_RegDst;
    logic                    i_MemWrEnable;
    logic                    i_MemToReg;
    logic                    i_RegWrEnable;
    logic [DataWidth-1:0]    o_WbResult;
    logic [RegAddrWidth-1:0] o_WbWriteReg;
    logic                    o_WbRegWrEnable;

    logic [31:0] testVec [MaxInst][ColCount];
    int          instCount    = 0;
    int          cycleCount   = 0;
    int          timeoutLimit = 0;
    int          checkIdx;
    // due cycle and line index of each instruction in flight
    int          dueQ [$];
    int          idxQ [$];

    execPipe execPipe_i (
        .i_Clock         (i_Clock),
        .i_rstN          (i_rstN),
        .i_InstRS        (i_InstRS),
        .i_InstRT        (i_InstRT),
        .i_InstRD        (i_InstRD),
        .i_InstIMM       (i_InstIMM),
        .i_AluControl    (i_AluControl),
        .i_AluSrcB       (i_AluSrcB),
        .i_RegDst        (i_RegDst),
        .i_MemWrEnable   (i_MemWrEnable),
        .i_MemToReg      (i_MemToReg),
        .i_RegWrEnable   (i_RegWrEnable),
        .o_WbResult      (o_WbResult),
        .o_WbWriteReg    (o_WbWriteReg),
        .o_WbRegWrEnable (o_WbRegWrEnable)
    );

    // ----------------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------------
    task automatic abortRun();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    // whole file read before reset so the timeout can be sized
    task automatic loadTestData();
        int          fd;
        int          fieldCount;
        string       line;
        logic [31:0] col [ColCount];
        fd = $fopen(DataFile, "r");
        assert (fd != 0) else begin
            $display("cannot open test data file %s", DataFile);
            abortRun();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // comment lines
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            fieldCount = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                                 col[7], col[8], col[9], col[10], col[11], col[12]);
            // blank line
            if (fieldCount <= 0) begin
                continue;
            end
            assert (fieldCount == ColCount) else begin
                $display("test data entry %0d has %0d fields instead of %0d",
                         instCount + 1, fieldCount, ColCount);
                abortRun();
            end
            assert (instCount < MaxInst) else begin
                $display("test data holds more than %0d instructions", MaxInst);
                abortRun();
            end
            for (int c = 0; c < ColCount; c++) begin
                testVec[instCount][c] = col[c];
            end
            instCount++;
        end
        $fclose(fd);
        assert (instCount > 0) else begin
            $display("test data file holds no instructions");
            abortRun();
        end
    endtask

    task automatic driveInst(input int idx);
        i_InstRS      = testVec[idx][ColRs][RegAddrWidth-1:0];
        i_InstRT      = testVec[idx][ColRt][RegAddrWidth-1:0];
        i_InstRD      = testVec[idx][ColRd][RegAddrWidth-1:0];
        i_InstIMM     = testVec[idx][ColImm];
        i_AluControl  = AluOp'(testVec[idx][ColOp][3:0]);
        i_AluSrcB     = testVec[idx][ColAluSrcB][0];
        i_RegDst      = testVec[idx][ColRegDst][0];
        i_MemWrEnable = testVec[idx][ColMemWr][0];
        i_MemToReg    = testVec[idx][ColMemToReg][0];
        i_RegWrEnable = testVec[idx][ColRegWr][0];
    endtask

    // all enables low so nothing is written
    task automatic driveBubble();
        i_InstRS      = '0;
        i_InstRT      = '0;
        i_InstRD      = '0;
        i_InstIMM     = '0;
        i_AluControl  = ALU_ADD;
        i_AluSrcB     = 1'b0;
        i_RegDst      = 1'b0;
        i_MemWrEnable = 1'b0;
        i_MemToReg    = 1'b0;
        i_RegWrEnable = 1'b0;
    endtask

    // ----------------------------------------------------------------------------
    // clock, cycle count and timeout
    // ----------------------------------------------------------------------------
    initial begin
        i_Clock = 1'b0;
        forever #50 i_Clock = ~i_Clock;
    end

    always @(posedge i_Clock) begin
        cycleCount = cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount > timeoutLimit) begin
            $display("timeout after %0d cycles, writeback checks did not finish", cycleCount);
            abortRun();
        end
    end

    // writeback is stable at the falling edge
    always @(negedge i_Clock) begin
        if (dueQ.size() > 0 && dueQ[0] == cycleCount) begin
            void'(dueQ.pop_front());
            checkIdx = idxQ.pop_front();
            checkField("o_WbRegWrEnable", o_WbRegWrEnable, testVec[checkIdx][ColExpWe]);
            // register and result only matter when the register file is written
            if (testVec[checkIdx][ColExpWe][0]) begin
                checkField("o_WbWriteReg", o_WbWriteReg, testVec[checkIdx][ColExpReg]);
                checkField("o_WbResult", o_WbResult, testVec[checkIdx][ColExpResult]);
            end
        end
    end

    // ----------------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------------
    initial begin
        i_rstN = 1'b0;
        driveBubble();
        loadTestData();
        timeoutLimit = instCount + WbLatency + TimeoutSlack;

        repeat (5) @(posedge i_Clock);
        #1 i_rstN = 1'b1;
        @(negedge i_Clock);
        assert (o_WbRegWrEnable === 1'b0) else begin
            $display("writeback enable is not low after reset");
            abortRun();
        end

        // one instruction per cycle 1 ns after the edge
        for (int i = 0; i < instCount; i++) begin
            @(posedge i_Clock);
            #1;
            driveInst(i);
            dueQ.push_back(cycleCount + WbLatency);
            idxQ.push_back(i);
        end
        @(posedge i_Clock);
        #1 driveBubble();

        wait (dueQ.size() == 0);
        @(posedge i_Clock);
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* tb/execPipe_testdata.txt */
# rs rt rd imm op aluSrcB regDst memWr memToReg regWr expWe expReg expResult, all hex
# op: 0 add 1 sub 2 and 3 or 4 xor 5 nor 6 slt 7 sll 8 srl
02 03 01 00000000 0 0 1 0 0 1 1 01 00000000
00 01 00 00000005 0 1 0 0 0 1 1 01 00000005
00 02 00 fffffff9 0 1 0 0 0 1 1 02 fffffff9
00 03 00 12345678 0 1 0 0 0 1 1 03 12345678
00 04 00 0000ff00 0 1 0 0 0 1 1 04 0000ff00
04 03 05 00000000 0 0 1 0 0 1 1 05 12355578
05 01 06 00000000 1 0 1 0 0 1 1 06 12355573
06 04 07 00000000 2 0 1 0 0 1 1 07 00005500
03 07 08 00000000 3 0 1 0 0 1 1 08 12345778
08 06 09 00000000 4 0 1 0 0 1 1 09 0001020b
09 00 0a 00000000 5 0 1 0 0 1 1 0a fffefdf4
02 01 0b 00000000 6 0 1 0 0 1 1 0b 00000001
01 02 0c 00000000 6 0 1 0 0 1 1 0c 00000000
03 0d 00 00000004 7 1 0 0 0 1 1 0d 23456780
02 01 0e 00000000 8 0 1 0 0 1 1 0e 07ffffff
00 0f 00 00000011 0 1 0 0 0 1 1 0f 00000011
00 0f 00 00000022 0 1 0 0 0 1 1 0f 00000022
0f 0f 10 00000000 0 0 1 0 0 1 1 10 00000044
00 00 00 00000077 0 1 0 0 0 1 1 00 00000077
00 00 11 00000000 0 0 1 0 0 1 1 11 00000000
00 10 12 00000000 3 0 1 0 0 1 1 12 00000044
00 13 00 cafef00d 0 1 0 0 0 1 1 13 cafef00d
00 13 00 00000020 0 1 0 1 0 0 0 00 00000000
00 00 00 00000000 0 0 0 0 0 0 0 00 00000000
00 14 00 00000020 0 1 0 0 1 1 1 14 cafef00d
00 00 00 00000000 0 0 0 0 0 0 0 00 00000000
00 15 00 600d0001 0 1 0 0 0 1 1 15 600d0001
00 00 00 00000000 0 0 0 0 0 0 0 00 00000000
00 15 00 0000003c 0 1 0 1 0 0 0 00 00000000
00 00 00 00000000 0 0 0 0 0 0 0 00 00000000
00 16 00 0000003c 0 1 0 0 1 1 1 16 600d0001
00 00 00 00000000 0 0 0 0 0 0 0 00 00000000
16 14 17 00000000 0 0 1 0 0 1 1 17 2b0bf00e
